//--- filelist.f
rv_isa_pkg.sv
core_ctrl_pkg.sv
core_ctrl_if.sv
control_unit.sv
alu.sv
reg_file.sv
imm_gen.sv
core.sv
core_assert.sv
tb_core.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_core -f filelist.f -o sim_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_core > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -qF '** FAIL **' sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation ended with status $sim_status, see sim.log"
    exit 1
fi
echo "simulation finished cleanly"
exit 0

//--- core_testdata.txt
// words 0x00..0x3f: program, one instruction per line, ends at the first empty word
// words 0x40..: number of expected stores, then one line per store: address data
@000
20000513 // addi x10, x0, 0x200
01900093 // addi x1, x0, 25
00700113 // addi x2, x0, 7
002081B3 // add  x3, x1, x2
00352023 // sw   x3, 0(x10)
40110233 // sub  x4, x2, x1
00452223 // sw   x4, 4(x10)
001222B3 // slt  x5, x4, x1
00211333 // sll  x6, x2, x2
0062E2B3 // or   x5, x5, x6
00552423 // sw   x5, 8(x10)
002253B3 // srl  x7, x4, x2
00752623 // sw   x7, 12(x10)
12345437 // lui  x8, 0x12345
67846413 // ori  x8, x8, 0x678
004444B3 // xor  x9, x8, x4
00952823 // sw   x9, 16(x10)
004475B3 // and  x11, x8, x4
00B52A23 // sw   x11, 20(x10)
00409613 // slli x12, x1, 4
0F064613 // xori x12, x12, 0xf0
01C25693 // srli x13, x4, 28
00D60633 // add  x12, x12, x13
00C52C23 // sw   x12, 24(x10)
FEF22713 // slti x14, x4, -17
0FF47793 // andi x15, x8, 0xff
40E78733 // sub  x14, x15, x14
00E52E23 // sw   x14, 28(x10)
00452803 // lw   x16, 4(x10)
03052023 // sw   x16, 32(x10)
06300013 // addi x0, x0, 99
02052223 // sw   x0, 36(x10)
00208463 // beq  x1, x2, +8  not taken
02152423 // sw   x1, 40(x10)
00109463 // bne  x1, x1, +8  not taken
02252623 // sw   x2, 44(x10)
00210463 // beq  x2, x2, +8  taken
02352823 // sw   x3, 48(x10)  skipped
00209463 // bne  x1, x2, +8  taken
02452823 // sw   x4, 48(x10)  skipped
00C008EF // jal  x17, +12
02352823 // sw   x3, 48(x10)  skipped
02452823 // sw   x4, 48(x10)  skipped
03152823 // sw   x17, 48(x10)
05A00913 // addi x18, x0, 0x5a
03252A23 // sw   x18, 52(x10)
0000006F // jal  x0, 0
@040
0000000E
00000200 00000020
00000204 FFFFFFEE
00000208 00000381
0000020C 01FFFFFF
00000210 EDCBA996
00000214 12345668
00000218 0000016F
0000021C 00000077
00000220 FFFFFFEE
00000224 00000000
00000228 00000019
0000022C 00000007
00000230 000000A4
00000234 0000005A

//--- tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;

    localparam int mem_words      = 256;
    localparam int image_words    = 128;
    localparam int max_program    = 64;
    localparam int timeout_factor = 40;
    localparam logic [6:0] count_slot = 7'd64; // store count followed by address/data pairs

    logic        clk;
    logic        reset;
    logic        memory_read;
    logic        memory_write;
    logic [31:0] address;
    logic [31:0] write_data;
    logic [31:0] read_data;

    logic [31:0] mem [mem_words];
    logic [31:0] image [image_words];

    int prog_len;
    int n_expected;
    int timeout_cycles;
    int store_index = 0;
    int cycle_count = 0;

    core #(.boot_address(32'h0000_0000)) i_core (
        .clk          (clk),
        .reset        (reset),
        .memory_read  (memory_read),
        .memory_write (memory_write),
        .address      (address),
        .write_data   (write_data),
        .read_data    (read_data)
    );

    bind core core_assert #(.boot_address(boot_address)) i_core_assert (
        .clk          (clk),
        .reset        (reset),
        .memory_read  (memory_read),
        .memory_write (memory_write),
        .address      (address)
    );

    assign read_data = mem[address[9:2]]; // answers in the same cycle

    function automatic logic [31:0] fill_word(input logic [7:0] index);
        return 32'hdead_0000 | {22'd0, index, 2'b00};
    endfunction

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic load_testdata();
        int i;
        for (i = 0; i < image_words; i++) begin
            image[i[6:0]] = 32'd0;
        end
        $readmemh("core_testdata.txt", image);
        // program ends at the first empty word
        prog_len = 0;
        while (prog_len < max_program && image[prog_len[6:0]] != 32'd0) begin
            prog_len++;
        end
        n_expected     = int'(image[count_slot]);
        timeout_cycles = timeout_factor * prog_len;
        assert (prog_len > 0 && n_expected > 0 && n_expected <= 31) else begin
            $display("testdata file holds no program or an unusable store count");
            $display("** FAIL **");
            $fatal(1, "bad testdata");
        end
        for (i = 0; i < mem_words; i++) begin
            if (i < prog_len) begin
                mem[i[7:0]] = image[i[6:0]];
            end else begin
                mem[i[7:0]] = fill_word(i[7:0]);
            end
        end
    endtask

    task automatic take_store();
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        assert (store_index < n_expected) else begin
            $display("store to %h after the last expected store", address);
            $display("** FAIL **");
            $fatal(1, "unexpected store");
        end
        exp_addr = image[7'(count_slot + 1 + 2 * store_index)];
        exp_data = image[7'(count_slot + 2 + 2 * store_index)];
        check_word($sformatf("store %0d address", store_index), exp_addr, address);
        check_word($sformatf("store %0d data", store_index), exp_data, write_data);
        mem[address[9:2]] = write_data;
        store_index++;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // memory model takes stores on the falling edge
    initial begin
        load_testdata();
        forever begin
            @(negedge clk);
            if (memory_write) begin
                take_store();
            end
        end
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (store_index < n_expected && cycle_count < timeout_cycles) begin
            @(posedge clk);
        end
        if (store_index == n_expected) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("timeout: only %0d of %0d expected stores seen within %0d cycles",
                     store_index, n_expected, timeout_cycles);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

//--- core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module core_assert #(
    parameter logic [31:0] boot_address = 32'h0000_0000
) (
    input wire        clk,
    input wire        reset,
    input wire        memory_read,
    input wire        memory_write,
    input wire [31:0] address
);

    // a read and a write never overlap on the shared bus
    bus_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(memory_read && memory_write))
        else $error("memory_read and memory_write high in the same cycle");

    single_write: assert property (@(posedge clk) disable iff (reset)
        memory_write |=> !memory_write)
        else $error("memory_write high for two cycles in a row");

    no_write_in_reset: assert property (@(posedge clk) reset |-> !memory_write)
        else $error("memory_write high while reset is asserted");

    // first cycle out of reset is the fetch from the boot address
    first_fetch: assert property (@(posedge clk)
        $fell(reset) |-> memory_read && !memory_write && address == boot_address)
        else $error("first cycle after reset is not a fetch from boot_address");

endmodule

`default_nettype wire

//--- core.sv
`timescale 1ns/1ps
`default_nettype none

module core import rv_isa_pkg::*, core_ctrl_pkg::*; #(
    parameter logic [31:0] boot_address = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset,
    output logic        memory_read,
    output logic        memory_write,
    output logic [31:0] address,
    output logic [31:0] write_data,
    input  logic [31:0] read_data
);

    logic [31:0] pc, ir, pc_old, a_reg, b_reg, mem_reg, alu_out_reg;
    logic [31:0] rdata1, rdata2, imm, alu_x, alu_y, alu_result, wb_data, pc_next;
    logic        zero, branch_taken, pc_load;

    core_ctrl_if ctrl ();

    control_unit i_control_unit (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode_t'(ir[6:0])),
        .ctrl   (ctrl)
    );

    reg_file i_reg_file (
        .clk        (clk),
        .reset      (reset),
        .rs1        (ir[19:15]),
        .rs2        (ir[24:20]),
        .rd         (ir[11:7]),
        .write_en   (ctrl.reg_write),
        .write_data (wb_data),
        .rdata1     (rdata1),
        .rdata2     (rdata2)
    );

    imm_gen i_imm_gen (.instr(ir), .imm(imm));

    alu i_alu (
        .alu_class   (ctrl.alu_class),
        .funct3      (ir[14:12]),
        .funct7_bit5 (ir[30]),
        .is_reg_op   (ir[6:0] == OPC_OP),
        .x           (alu_x),
        .y           (alu_y),
        .result      (alu_result),
        .zero        (zero)
    );

    always_comb begin
        case (ctrl.src_a)
            A_PC:     alu_x = pc;
            A_RS1:    alu_x = a_reg;
            A_PC_OLD: alu_x = pc_old;
            default:  alu_x = 32'd0;
        endcase
        case (ctrl.src_b)
            B_RS2:   alu_y = b_reg;
            B_FOUR:  alu_y = 32'd4;
            B_IMM:   alu_y = imm;
            default: alu_y = 32'd0;
        endcase
    end

    always_comb begin
        branch_taken = 1'b0;
        if (ctrl.branch) begin
            case (ir[14:12])
                F3_BEQ:  branch_taken = zero;
                F3_BNE:  branch_taken = !zero;
                default: branch_taken = 1'b0;
            endcase
        end
    end

    assign pc_load = ctrl.pc_write || branch_taken;
    assign pc_next = ctrl.pc_from_alu_reg ? alu_out_reg : alu_result;
    assign wb_data = (ctrl.wb_sel == WB_MEM_REG) ? mem_reg : alu_out_reg;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= boot_address;
        end else if (pc_load) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ir_write) begin
            ir     <= read_data;
            pc_old <= pc;  // pc of the instruction being fetched
        end
        a_reg       <= rdata1;
        b_reg       <= rdata2;
        mem_reg     <= read_data;
        alu_out_reg <= alu_result;
    end

    assign address      = ctrl.addr_from_alu ? alu_out_reg : pc;
    assign memory_read  = ctrl.mem_read;
    assign memory_write = ctrl.mem_write;
    assign write_data   = b_reg;

endmodule

`default_nettype wire

//--- imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen import rv_isa_pkg::*; (
    input  logic [31:0] instr,
    output logic [31:0] imm
);

    opcode_t opcode;

    assign opcode = opcode_t'(instr[6:0]);

    always_comb begin
        case (opcode)
            OPC_OP_IMM,
            OPC_LOAD:   imm = {{20{instr[31]}}, instr[31:20]};
            OPC_STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OPC_BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            OPC_LUI:    imm = {instr[31:12], 12'd0};
            OPC_JAL: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default:    imm = 32'd0; // r-type has no immediate
        endcase
    end

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        write_en,
    input  logic [31:0] write_data,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (write_en && rd != 5'd0) begin // x0 stays zero
            regs[rd] <= write_data;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import rv_isa_pkg::*; (
    input  alu_class_t  alu_class,
    input  logic [2:0]  funct3,
    input  logic        funct7_bit5,
    input  logic        is_reg_op,
    input  logic [31:0] x,
    input  logic [31:0] y,
    output logic [31:0] result,
    output logic        zero
);

    alu_op_t op;

    always_comb begin
        op = ALU_ADD;
        case (alu_class)
            CLS_SUB: op = ALU_SUB;
            CLS_FUNCT: begin
                case (funct3)
                    F3_ADD:  op = (is_reg_op && funct7_bit5) ? ALU_SUB : ALU_ADD;
                    F3_SLL:  op = ALU_SLL;
                    F3_SLT:  op = ALU_SLT;
                    F3_XOR:  op = ALU_XOR;
                    F3_SRL:  op = ALU_SRL;
                    F3_OR:   op = ALU_OR;
                    F3_AND:  op = ALU_AND;
                    default: op = ALU_ADD;
                endcase
            end
            default: op = ALU_ADD;
        endcase
    end

    always_comb begin
        case (op)
            ALU_SUB: result = x - y;
            ALU_AND: result = x & y;
            ALU_OR:  result = x | y;
            ALU_XOR: result = x ^ y;
            ALU_SLT: result = {31'd0, $signed(x) < $signed(y)};
            ALU_SLL: result = x << y[4:0];
            ALU_SRL: result = x >> y[4:0];
            default: result = x + y;
        endcase
    end

    assign zero = (result == 32'd0);

endmodule

`default_nettype wire

//--- control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  opcode_t opcode,
    core_ctrl_if.ctrl ctrl
);

    ctrl_state_t state, state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_FETCH;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        ctrl.pc_write        = 1'b0;
        ctrl.branch          = 1'b0;
        ctrl.addr_from_alu   = 1'b0;
        ctrl.mem_read        = 1'b0;
        ctrl.mem_write       = 1'b0;
        ctrl.ir_write        = 1'b0;
        ctrl.reg_write       = 1'b0;
        ctrl.pc_from_alu_reg = 1'b0;
        ctrl.alu_class       = CLS_ADD;
        ctrl.src_a           = A_RS1;
        ctrl.src_b           = B_IMM;
        ctrl.wb_sel          = WB_ALU_REG;
        state_next           = S_FETCH;
        case (state)
            S_FETCH: begin
                ctrl.mem_read = 1'b1;
                ctrl.ir_write = 1'b1;
                ctrl.pc_write = 1'b1;     // pc + 4
                ctrl.src_a    = A_PC;
                ctrl.src_b    = B_FOUR;
                state_next    = S_DECODE;
            end
            S_DECODE: begin
                // branch/jump target into alu_out_reg; lui passes imm through
                ctrl.src_a = (opcode == OPC_LUI) ? A_ZERO : A_PC_OLD;
                case (opcode)
                    OPC_OP:     state_next = S_EXEC_R;
                    OPC_OP_IMM: state_next = S_EXEC_I;
                    OPC_LOAD,
                    OPC_STORE:  state_next = S_MEM_ADDR;
                    OPC_BRANCH: state_next = S_BRANCH;
                    OPC_JAL:    state_next = S_JUMP;
                    OPC_LUI:    state_next = S_LUI_WB;
                    default:    state_next = S_FETCH;
                endcase
            end
            S_EXEC_R: begin
                ctrl.alu_class = CLS_FUNCT;
                ctrl.src_b     = B_RS2;
                state_next     = S_ALU_WB;
            end
            S_EXEC_I: begin
                ctrl.alu_class = CLS_FUNCT;
                state_next     = S_ALU_WB;
            end
            S_MEM_ADDR: state_next = (opcode == OPC_STORE) ? S_MEM_WR : S_MEM_RD;
            S_MEM_RD: begin
                ctrl.addr_from_alu = 1'b1;
                ctrl.mem_read      = 1'b1;
                state_next         = S_MEM_WB;
            end
            S_MEM_WB: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_MEM_REG;
            end
            S_MEM_WR: begin
                ctrl.addr_from_alu = 1'b1;
                ctrl.mem_write     = 1'b1;
            end
            S_BRANCH: begin
                ctrl.branch          = 1'b1; // core decides on zero
                ctrl.pc_from_alu_reg = 1'b1;
                ctrl.alu_class       = CLS_SUB;
                ctrl.src_b           = B_RS2;
            end
            S_JUMP: begin
                ctrl.pc_write        = 1'b1;
                ctrl.pc_from_alu_reg = 1'b1;
                ctrl.src_a           = A_PC_OLD; // link value pc_old + 4
                ctrl.src_b           = B_FOUR;
                state_next           = S_ALU_WB;
            end
            S_LUI_WB,
            S_ALU_WB: ctrl.reg_write = 1'b1;
            default: state_next = S_FETCH;
        endcase
    end

endmodule

`default_nettype wire

//--- core_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface core_ctrl_if import rv_isa_pkg::*, core_ctrl_pkg::*; ();

    logic       pc_write;
    logic       branch;
    logic       addr_from_alu;   // bus address from alu_out_reg instead of pc
    logic       mem_read;
    logic       mem_write;
    logic       ir_write;
    logic       reg_write;
    logic       pc_from_alu_reg;
    alu_class_t alu_class;
    src_a_t     src_a;
    src_b_t     src_b;
    wb_sel_t    wb_sel;

    modport ctrl (
        output pc_write, branch, addr_from_alu, mem_read, mem_write, ir_write,
               reg_write, pc_from_alu_reg, alu_class, src_a, src_b, wb_sel
    );

    modport dp (
        input pc_write, branch, addr_from_alu, mem_read, mem_write, ir_write,
              reg_write, pc_from_alu_reg, alu_class, src_a, src_b, wb_sel
    );

endinterface

`default_nettype wire

//--- core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

    typedef enum logic [3:0] {
        S_FETCH    = 4'd0,
        S_DECODE   = 4'd1,
        S_EXEC_R   = 4'd2,
        S_EXEC_I   = 4'd3,
        S_MEM_ADDR = 4'd4,
        S_MEM_RD   = 4'd5,
        S_MEM_WB   = 4'd6,
        S_MEM_WR   = 4'd7,
        S_BRANCH   = 4'd8,
        S_JUMP     = 4'd9,
        S_LUI_WB   = 4'd10,
        S_ALU_WB   = 4'd11
    } ctrl_state_t;

    typedef enum logic [1:0] {A_PC, A_RS1, A_PC_OLD, A_ZERO} src_a_t;

    typedef enum logic [1:0] {B_RS2, B_FOUR, B_IMM} src_b_t;

    typedef enum logic {WB_ALU_REG, WB_MEM_REG} wb_sel_t;

endpackage

`default_nettype wire

//--- rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    // funct3 of the ALU operations
    localparam logic [2:0] F3_ADD = 3'b000; // also SUB
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct3 of the branches
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL
    } alu_op_t;

    typedef enum logic [1:0] {
        CLS_ADD, CLS_SUB, CLS_FUNCT // op decoded from funct3 and funct7
    } alu_class_t;

endpackage

`default_nettype wire
